// ==== dv/tb_axis_packet_bridge.sv ====
/*
 * Random packet traffic with random sink back-pressure, checked against a queue model.
 * Metadata and counter accesses happen only while the packet path is idle.
 */
`timescale 1ns/1ps

module tb_axis_packet_bridge;

    localparam int ACCEPT_TIMEOUT = 100;
    localparam int WB_TIMEOUT     = 20;
    localparam int DRAIN_TIMEOUT  = 500;

    typedef struct packed {
        logic [pkt_axis_pkg::DATA_BYTE_WID*8-1:0] tdata;
        logic [pkt_axis_pkg::DATA_BYTE_WID-1:0]   tkeep;
        logic                                     tlast;
        pkt_axis_pkg::tid_t                       tid;
        pkt_axis_pkg::tdest_t                     tdest;
        pkt_axis_pkg::tuser_t                     tuser;
    } axis_beat_t;

    logic                                     __axis_if;
    logic                                     arst_n;
    logic                                     wb_cyc;
    logic                                     wb_stb;
    logic                                     wb_we;
    logic [pkt_axis_pkg::WB_ADR_WID-1:0]      wb_adr;
    logic [31:0]                              wb_dat_w;
    logic [31:0]                              wb_dat_r;
    logic                                     wb_ack;
    logic                                     pkt_valid;
    logic                                     pkt_rdy;
    logic [pkt_axis_pkg::DATA_BYTE_WID*8-1:0] pkt_data;
    logic                                     pkt_eop;
    logic [pkt_axis_pkg::MTY_WID-1:0]         pkt_mty;
    logic                                     axis_tvalid;
    logic                                     axis_tready;
    logic [pkt_axis_pkg::DATA_BYTE_WID*8-1:0] axis_tdata;
    logic [pkt_axis_pkg::DATA_BYTE_WID-1:0]   axis_tkeep;
    logic                                     axis_tlast;
    pkt_axis_pkg::tid_t                       axis_tid;
    pkt_axis_pkg::tdest_t                     axis_tdest;
    pkt_axis_pkg::tuser_t                     axis_tuser;

    // Model state
    axis_beat_t           exp_q[$];
    axis_beat_t           held_beat;
    logic                 out_held;
    logic                 tready_random;
    pkt_axis_pkg::tid_t   meta_tid;
    pkt_axis_pkg::tdest_t meta_tdest;
    pkt_axis_pkg::tuser_t meta_tuser;
    int                   tlast_count;
    int                   beats_checked;
    int                   mismatch_count;
    int                   other_errors;

    axis_packet_bridge axis_packet_bridge_inst (
        .__axis_if   (__axis_if),
        .arst_n      (arst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .pkt_valid   (pkt_valid),
        .pkt_rdy     (pkt_rdy),
        .pkt_data    (pkt_data),
        .pkt_eop     (pkt_eop),
        .pkt_mty     (pkt_mty),
        .axis_tvalid (axis_tvalid),
        .axis_tready (axis_tready),
        .axis_tdata  (axis_tdata),
        .axis_tkeep  (axis_tkeep),
        .axis_tlast  (axis_tlast),
        .axis_tid    (axis_tid),
        .axis_tdest  (axis_tdest),
        .axis_tuser  (axis_tuser)
    );

    always #5 __axis_if = ~__axis_if;

    task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_beat(input axis_beat_t got, input axis_beat_t exp);
        check_field("axis_tdata", got.tdata, exp.tdata);
        check_field("axis_tkeep", got.tkeep, exp.tkeep);
        check_field("axis_tlast", got.tlast, exp.tlast);
        check_field("axis_tid", got.tid, exp.tid);
        check_field("axis_tdest", got.tdest, exp.tdest);
        check_field("axis_tuser", got.tuser, exp.tuser);
    endtask

    function automatic axis_beat_t out_beat();
        return '{axis_tdata, axis_tkeep, axis_tlast, axis_tid, axis_tdest, axis_tuser};
    endfunction

    // Big-endian packet beat to the little-endian AXI-Stream beat it should become
    function automatic axis_beat_t expected_beat(input logic [63:0] data, input logic eop,
                                                 input logic [2:0] mty);
        axis_beat_t                             beat;
        logic [pkt_axis_pkg::DATA_BYTE_WID-1:0] all_ones;
        all_ones = '1;
        for (int i = 0; i < pkt_axis_pkg::DATA_BYTE_WID; i++) begin
            beat.tdata[8*i +: 8] = data[8*(pkt_axis_pkg::DATA_BYTE_WID-1-i) +: 8];
        end
        // Empty bytes sit at the top of the little-endian word
        beat.tkeep = eop ? (all_ones >> mty) : all_ones;
        beat.tlast = eop;
        beat.tid   = meta_tid;
        beat.tdest = meta_tdest;
        beat.tuser = meta_tuser;
        return beat;
    endfunction

    task automatic check_idle();
        check_field("axis_tvalid", axis_tvalid, 1'b0);
        check_field("pkt_rdy", pkt_rdy, 1'b0);
        check_field("wb_ack", wb_ack, 1'b0);
    endtask

    // Starts and ends on a falling edge
    task automatic wb_access(input pkt_axis_pkg::meta_reg_e adr, input logic we,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge __axis_if);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(posedge __axis_if);
        while (!wb_ack && waited < WB_TIMEOUT) begin
            waited++;
            @(posedge __axis_if);
        end
        assert (wb_ack) else begin
            other_errors++;
            $display("Wishbone access to %s timed out waiting for ack", adr.name());
        end
        rdata = wb_dat_r;
        @(negedge __axis_if);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_expect(input pkt_axis_pkg::meta_reg_e adr, input logic [31:0] exp);
        logic [31:0] rd;
        wb_access(adr, 1'b0, 32'd0, rd);
        check_field({"wb_dat_r ", adr.name()}, rd, exp);
    endtask

    task automatic send_beat(input logic [63:0] data, input logic eop, input logic [2:0] mty);
        int waited;
        int gap;
        waited = 0;
        gap    = 0;
        // Random idle cycles before the beat
        while (($urandom % 4 == 0) && gap < 3) begin
            gap++;
            @(negedge __axis_if);
        end
        pkt_valid = 1'b1;
        pkt_data  = data;
        pkt_eop   = eop;
        pkt_mty   = mty;
        @(posedge __axis_if);
        while (!pkt_rdy && waited < ACCEPT_TIMEOUT) begin
            waited++;
            @(posedge __axis_if);
        end
        assert (pkt_rdy) else begin
            other_errors++;
            $display("Packet beat was not accepted within %0d cycles", ACCEPT_TIMEOUT);
        end
        @(negedge __axis_if);
        pkt_valid = 1'b0;
    endtask

    task automatic send_packet(input int len);
        logic eop;
        for (int b = 0; b < len; b++) begin
            eop = (b == len - 1);
            send_beat({$urandom, $urandom}, eop, eop ? 3'($urandom % 8) : 3'd0);
        end
    endtask

    task automatic drain_output();
        int waited;
        waited        = 0;
        tready_random = 1'b0;
        while ((exp_q.size() != 0 || axis_tvalid) && waited < DRAIN_TIMEOUT) begin
            waited++;
            @(negedge __axis_if);
        end
        assert (exp_q.size() == 0 && !axis_tvalid) else begin
            other_errors++;
            $display("Drain timed out with %0d beats still expected", exp_q.size());
        end
    endtask

    task automatic run_round(input int n_pkts);
        logic [31:0] rd;
        meta_tid   = pkt_axis_pkg::tid_t'($urandom);
        meta_tdest = pkt_axis_pkg::tdest_t'($urandom);
        meta_tuser = pkt_axis_pkg::tuser_t'($urandom);
        wb_access(pkt_axis_pkg::REG_TID, 1'b1, 32'(meta_tid), rd);
        wb_access(pkt_axis_pkg::REG_TDEST, 1'b1, 32'(meta_tdest), rd);
        wb_access(pkt_axis_pkg::REG_TUSER, 1'b1, 32'(meta_tuser), rd);
        read_expect(pkt_axis_pkg::REG_TID, 32'(meta_tid));
        read_expect(pkt_axis_pkg::REG_TDEST, 32'(meta_tdest));
        read_expect(pkt_axis_pkg::REG_TUSER, 32'(meta_tuser));
        tready_random = 1'b1;
        repeat (n_pkts) send_packet(1 + $urandom % 6);
        drain_output();
        read_expect(pkt_axis_pkg::REG_PKT_CNT, 32'(tlast_count));
        // Any write clears the counter
        wb_access(pkt_axis_pkg::REG_PKT_CNT, 1'b1, 32'hffff_ffff, rd);
        tlast_count = 0;
        read_expect(pkt_axis_pkg::REG_PKT_CNT, 32'd0);
    endtask

    // Sink back-pressure
    always @(negedge __axis_if) begin
        axis_tready = tready_random ? ($urandom % 4 != 0) : 1'b1;
    end

    // Reference model and output checks, sampled at the rising edge
    always @(posedge __axis_if) begin
        if (arst_n) begin
            if (pkt_valid && pkt_rdy) begin
                exp_q.push_back(expected_beat(pkt_data, pkt_eop, pkt_mty));
                // Every accepted end of packet must leave as one tlast beat
                if (pkt_eop) tlast_count++;
            end
            if (out_held) begin
                check_field("axis_tvalid", axis_tvalid, 1'b1);
                compare_beat(out_beat(), held_beat);
            end
            if (axis_tvalid && axis_tready) begin
                assert (exp_q.size() != 0) else begin
                    other_errors++;
                    $display("Output beat at %0t with no beat outstanding", $time);
                end
                if (exp_q.size() != 0) begin
                    compare_beat(out_beat(), exp_q.pop_front());
                    beats_checked++;
                end
            end
            out_held  = axis_tvalid && !axis_tready;
            held_beat = out_beat();
        end
    end

    initial begin
        void'($urandom(32'h09f9d31a));
        __axis_if      = 1'b0;
        arst_n         = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        pkt_valid      = 1'b0;
        pkt_data       = '0;
        pkt_eop        = 1'b0;
        pkt_mty        = '0;
        axis_tready    = 1'b0;
        tready_random  = 1'b0;
        out_held       = 1'b0;
        held_beat      = '0;
        meta_tid       = '0;
        meta_tdest     = '0;
        meta_tuser     = '0;
        tlast_count    = 0;
        beats_checked  = 0;
        mismatch_count = 0;
        other_errors   = 0;

        repeat (4) begin
            @(negedge __axis_if);
            check_idle();
        end
        arst_n = 1'b1;
        #1 check_idle();
        // Still the first cycle out of reset, values before the edge
        @(posedge __axis_if);
        check_idle();
        @(negedge __axis_if);

        run_round(40);
        run_round(60);

        $display("Summary: %0d mismatches, %0d other errors, %0d beats checked",
                 mismatch_count, other_errors, beats_checked);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_axis_packet_bridge

// ==== source/axis_bus.sv ====
/*
 * Internal AXI-Stream path, little-endian, no tstrb.
 * Transfer happens on an edge with tvalid and tready both high.
 */
`timescale 1ns/1ps

interface axis_bus;

    logic                                     tvalid;
    logic                                     tready;
    logic [pkt_axis_pkg::DATA_BYTE_WID*8-1:0] tdata;
    logic [pkt_axis_pkg::DATA_BYTE_WID-1:0]   tkeep;
    logic                                     tlast;
    pkt_axis_pkg::tid_t                       tid;
    pkt_axis_pkg::tdest_t                     tdest;
    pkt_axis_pkg::tuser_t                     tuser;

    modport tx (
        output tvalid,
        output tdata,
        output tkeep,
        output tlast,
        output tid,
        output tdest,
        output tuser,
        input  tready
    );

    modport rx (
        input  tvalid,
        input  tdata,
        input  tkeep,
        input  tlast,
        input  tid,
        input  tdest,
        input  tuser,
        output tready
    );

endinterface : axis_bus

// ==== source/axis_from_packet_adapter.sv ====
/*
 * One register stage from big-endian packet beats to little-endian AXI-Stream.
 * The stage never stalls. Downstream must take every registered beat (see skid buffer).
 */
`timescale 1ns/1ps

module axis_from_packet_adapter (
    input  logic                 __axis_if,
    input  logic                 arst_n,
    packet_bus.sink              pkt,
    axis_bus.tx                  axis,
    input  pkt_axis_pkg::tid_t   tid,
    input  pkt_axis_pkg::tdest_t tdest,
    input  pkt_axis_pkg::tuser_t tuser
);

    logic pkt_xfer;

    // Keep the lowest DATA_BYTE_WID - mty bytes
    function automatic logic [pkt_axis_pkg::DATA_BYTE_WID-1:0] mty_to_tkeep(
        input logic [pkt_axis_pkg::MTY_WID-1:0] mty
    );
        logic [pkt_axis_pkg::DATA_BYTE_WID-1:0] keep;
        for (int i = 0; i < pkt_axis_pkg::DATA_BYTE_WID; i++) begin
            keep[i] = (i < (pkt_axis_pkg::DATA_BYTE_WID - int'(mty)));
        end
        return keep;
    endfunction

    // Ready comes straight from the skid buffer, which reserves room for our beat
    assign pkt.rdy  = axis.tready;
    assign pkt_xfer = pkt.valid && pkt.rdy;

    // tvalid lasts exactly one cycle per accepted beat
    always_ff @(posedge __axis_if or negedge arst_n) begin
        if (!arst_n) begin
            axis.tvalid <= 1'b0;
        end else begin
            axis.tvalid <= pkt_xfer;
        end
    end

    // Payload and metadata sampled together with the beat
    always_ff @(posedge __axis_if) begin
        if (pkt_xfer) begin
            axis.tdata <= {<<8{pkt.data}};
            axis.tkeep <= pkt.eop ? mty_to_tkeep(pkt.mty) : '1;
            axis.tlast <= pkt.eop;
            axis.tid   <= tid;
            axis.tdest <= tdest;
            axis.tuser <= tuser;
        end
    end

    a_mty_only_on_eop : assert property (
        @(posedge __axis_if) disable iff (!arst_n)
        (pkt.valid && !pkt.eop) |-> (pkt.mty == '0)
    );

endmodule : axis_from_packet_adapter

// ==== source/axis_meta_regs.sv ====
/*
 * Wishbone classic slave, ack one cycle after the strobe is seen, one ack per strobe.
 * Master must hold cyc, stb, adr and data until ack. Only the low bits of dat_w are used.
 */
`timescale 1ns/1ps

module axis_meta_regs (
    input  logic                    __axis_if,
    input  logic                    arst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  pkt_axis_pkg::meta_reg_e wb_adr,
    input  logic [31:0]             wb_dat_w,
    output logic [31:0]             wb_dat_r,
    output logic                    wb_ack,
    output pkt_axis_pkg::tid_t      tid,
    output pkt_axis_pkg::tdest_t    tdest,
    output pkt_axis_pkg::tuser_t    tuser,
    input  logic                    pkt_done
);

    logic                                 wb_req;
    logic                                 cnt_clr;
    logic [pkt_axis_pkg::PKT_CNT_WID-1:0] pkt_cnt;

    // New access this cycle; the ack term keeps a held strobe from acking twice
    assign wb_req  = wb_cyc && wb_stb && !wb_ack;
    assign cnt_clr = wb_req && wb_we && (wb_adr == pkt_axis_pkg::REG_PKT_CNT);

    always_ff @(posedge __axis_if or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
            tid    <= '0;
            tdest  <= '0;
            tuser  <= '0;
        end else begin
            wb_ack <= wb_req;
            if (wb_req && wb_we) begin
                case (wb_adr)
                    pkt_axis_pkg::REG_TID:   tid   <= wb_dat_w[pkt_axis_pkg::TID_WID-1:0];
                    pkt_axis_pkg::REG_TDEST: tdest <= wb_dat_w[pkt_axis_pkg::TDEST_WID-1:0];
                    pkt_axis_pkg::REG_TUSER: tuser <= wb_dat_w[pkt_axis_pkg::TUSER_WID-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Clear wins over a packet finishing on the same edge
    always_ff @(posedge __axis_if or negedge arst_n) begin
        if (!arst_n) begin
            pkt_cnt <= '0;
        end else if (cnt_clr) begin
            pkt_cnt <= '0;
        end else if (pkt_done) begin
            pkt_cnt <= pkt_cnt + 1'b1;
        end
    end

    // Read data captured with the edge that raises ack
    always_ff @(posedge __axis_if) begin
        if (wb_req) begin
            case (wb_adr)
                pkt_axis_pkg::REG_TID:     wb_dat_r <= 32'(tid);
                pkt_axis_pkg::REG_TDEST:   wb_dat_r <= 32'(tdest);
                pkt_axis_pkg::REG_TUSER:   wb_dat_r <= 32'(tuser);
                pkt_axis_pkg::REG_PKT_CNT: wb_dat_r <= 32'(pkt_cnt);
                default:                   wb_dat_r <= '0;
            endcase
        end
    end

    // Master holds the request through the ack cycle
    a_req_held : assert property (
        @(posedge __axis_if) disable iff (!arst_n)
        wb_req |=> (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we))
    );

endmodule : axis_meta_regs

// ==== source/axis_packet_bridge.sv ====
/*
 * Packet to AXI-Stream egress bridge with Wishbone metadata registers.
 * Single clock domain. No packet error handling and no tstrb.
 */
`timescale 1ns/1ps

module axis_packet_bridge (
    input  logic                                     __axis_if,
    input  logic                                     arst_n,
    input  logic                                     wb_cyc,
    input  logic                                     wb_stb,
    input  logic                                     wb_we,
    input  logic [pkt_axis_pkg::WB_ADR_WID-1:0]      wb_adr,
    input  logic [31:0]                              wb_dat_w,
    output logic [31:0]                              wb_dat_r,
    output logic                                     wb_ack,
    input  logic                                     pkt_valid,
    output logic                                     pkt_rdy,
    input  logic [pkt_axis_pkg::DATA_BYTE_WID*8-1:0] pkt_data,
    input  logic                                     pkt_eop,
    input  logic [pkt_axis_pkg::MTY_WID-1:0]         pkt_mty,
    output logic                                     axis_tvalid,
    input  logic                                     axis_tready,
    output logic [pkt_axis_pkg::DATA_BYTE_WID*8-1:0] axis_tdata,
    output logic [pkt_axis_pkg::DATA_BYTE_WID-1:0]   axis_tkeep,
    output logic                                     axis_tlast,
    output pkt_axis_pkg::tid_t                       axis_tid,
    output pkt_axis_pkg::tdest_t                     axis_tdest,
    output pkt_axis_pkg::tuser_t                     axis_tuser
);

    packet_bus pkt_bus ();
    axis_bus   adp_axis ();
    axis_bus   out_axis ();

    pkt_axis_pkg::tid_t   meta_tid;
    pkt_axis_pkg::tdest_t meta_tdest;
    pkt_axis_pkg::tuser_t meta_tuser;
    logic                 pkt_done;

    assign pkt_bus.valid = pkt_valid;
    assign pkt_bus.data  = pkt_data;
    assign pkt_bus.eop   = pkt_eop;
    assign pkt_bus.mty   = pkt_mty;
    assign pkt_rdy       = pkt_bus.rdy;

    assign axis_tvalid     = out_axis.tvalid;
    assign out_axis.tready = axis_tready;
    assign axis_tdata      = out_axis.tdata;
    assign axis_tkeep      = out_axis.tkeep;
    assign axis_tlast      = out_axis.tlast;
    assign axis_tid        = out_axis.tid;
    assign axis_tdest      = out_axis.tdest;
    assign axis_tuser      = out_axis.tuser;

    // A packet counts once its last beat leaves the bridge
    assign pkt_done = axis_tvalid && axis_tready && axis_tlast;

    axis_meta_regs axis_meta_regs_inst (
        .__axis_if (__axis_if),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (pkt_axis_pkg::meta_reg_e'(wb_adr)),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .tid       (meta_tid),
        .tdest     (meta_tdest),
        .tuser     (meta_tuser),
        .pkt_done  (pkt_done)
    );

    axis_from_packet_adapter axis_from_packet_adapter_inst (
        .__axis_if (__axis_if),
        .arst_n    (arst_n),
        .pkt       (pkt_bus.sink),
        .axis      (adp_axis.tx),
        .tid       (meta_tid),
        .tdest     (meta_tdest),
        .tuser     (meta_tuser)
    );

    axis_skid_buffer axis_skid_buffer_inst (
        .__axis_if (__axis_if),
        .arst_n    (arst_n),
        .axis_in   (adp_axis.rx),
        .axis_out  (out_axis.tx)
    );

endmodule : axis_packet_bridge

// ==== source/axis_skid_buffer.sv ====
/*
 * Two-entry FIFO behind the adapter stage. Input tvalid is written unconditionally,
 * so tready is held low whenever the in-flight beat could fill the last entry.
 */
`timescale 1ns/1ps

module axis_skid_buffer (
    input  logic __axis_if,
    input  logic arst_n,
    axis_bus.rx  axis_in,
    axis_bus.tx  axis_out
);

    logic [pkt_axis_pkg::DATA_BYTE_WID*8-1:0] tdata_mem [2];
    logic [pkt_axis_pkg::DATA_BYTE_WID-1:0]   tkeep_mem [2];
    logic                                     tlast_mem [2];
    pkt_axis_pkg::tid_t                       tid_mem   [2];
    pkt_axis_pkg::tdest_t                     tdest_mem [2];
    pkt_axis_pkg::tuser_t                     tuser_mem [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic [2:0] fill;
    logic       rdy_en;
    logic       wr;
    logic       pop;

    // Adapter beats cannot wait, so any valid is a write
    assign wr  = axis_in.tvalid;
    assign pop = axis_out.tvalid && axis_out.tready;

    // Stored entries plus the beat arriving now
    assign fill           = {1'b0, count} + {2'b00, axis_in.tvalid};
    assign axis_in.tready = rdy_en && (fill < 3'd2);

    // Holds ready low for the first cycle out of reset
    always_ff @(posedge __axis_if or negedge arst_n) begin
        if (!arst_n) begin
            rdy_en <= 1'b0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            rdy_en <= 1'b1;
            if (wr) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            case ({wr, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge __axis_if) begin
        if (wr) begin
            tdata_mem[wr_ptr] <= axis_in.tdata;
            tkeep_mem[wr_ptr] <= axis_in.tkeep;
            tlast_mem[wr_ptr] <= axis_in.tlast;
            tid_mem[wr_ptr]   <= axis_in.tid;
            tdest_mem[wr_ptr] <= axis_in.tdest;
            tuser_mem[wr_ptr] <= axis_in.tuser;
        end
    end

    // Head entry, stable until popped
    assign axis_out.tvalid = (count != 2'd0);
    assign axis_out.tdata  = tdata_mem[rd_ptr];
    assign axis_out.tkeep  = tkeep_mem[rd_ptr];
    assign axis_out.tlast  = tlast_mem[rd_ptr];
    assign axis_out.tid    = tid_mem[rd_ptr];
    assign axis_out.tdest  = tdest_mem[rd_ptr];
    assign axis_out.tuser  = tuser_mem[rd_ptr];

    a_no_overflow : assert property (
        @(posedge __axis_if) disable iff (!arst_n) !(wr && (count == 2'd2) && !pop)
    );

endmodule : axis_skid_buffer

// ==== source/packet_bus.sv ====
/*
 * Big-endian packet beat path. Byte 0 of data is the most significant byte.
 * mty counts unused bytes at the low end and is only meaningful with eop.
 */
`timescale 1ns/1ps

interface packet_bus;

    logic                                     valid;
    logic                                     rdy;
    logic [pkt_axis_pkg::DATA_BYTE_WID*8-1:0] data;
    logic                                     eop;
    logic [pkt_axis_pkg::MTY_WID-1:0]         mty;

    // Beat producer
    modport source (
        output valid,
        output data,
        output eop,
        output mty,
        input  rdy
    );

    // Beat consumer
    modport sink (
        input  valid,
        input  data,
        input  eop,
        input  mty,
        output rdy
    );

endinterface : packet_bus

// ==== source/pkt_axis_pkg.sv ====
/*
 * Widths, metadata types and Wishbone register map shared by the bridge and its testbench.
 * Beat width is fixed at DATA_BYTE_WID bytes. No other widths are supported.
 */
package pkt_axis_pkg;

    // Beat geometry
    localparam int DATA_BYTE_WID = 8;
    localparam int MTY_WID       = $clog2(DATA_BYTE_WID);

    // Stream metadata widths
    localparam int TID_WID   = 4;
    localparam int TDEST_WID = 4;
    localparam int TUSER_WID = 8;

    // Completed packets, wraps at full scale
    localparam int PKT_CNT_WID = 16;

    // Wishbone word address width
    localparam int WB_ADR_WID = 2;

    typedef logic [TID_WID-1:0]   tid_t;
    typedef logic [TDEST_WID-1:0] tdest_t;
    typedef logic [TUSER_WID-1:0] tuser_t;

    // Register map, word addressed
    // REG_PKT_CNT reads the counter, any write clears it
    typedef enum logic [WB_ADR_WID-1:0] {
        REG_TID     = 2'd0,
        REG_TDEST   = 2'd1,
        REG_TUSER   = 2'd2,
        REG_PKT_CNT = 2'd3
    } meta_reg_e;

endpackage : pkt_axis_pkg

// ==== verilog.f ====
source/pkt_axis_pkg.sv
source/packet_bus.sv
source/axis_bus.sv
source/axis_meta_regs.sv
source/axis_from_packet_adapter.sv
source/axis_skid_buffer.sv
source/axis_packet_bridge.sv
dv/tb_axis_packet_bridge.sv
